//--- hdl/pmp_pkg.sv
// pmp gate shared definitions
package pmp_pkg;

	// bus and region sizes
	localparam int unsigned NUM_REGIONS = 4;
	localparam int unsigned ADDR_W = 32;
	localparam int unsigned DATA_W = 32;
	localparam int unsigned MASK_W = 4;
	localparam int unsigned SRC_W = 8;
	// region address holds byte address bits 31..2
	localparam int unsigned PMP_ADDR_W = 30;

	// cpu register map, word index from a_address[9:2]
	localparam int unsigned REG_CFG = 0;
	// region addresses follow at 1..4
	localparam int unsigned REG_ADDR_BASE = 1;
	localparam int unsigned REG_GO_IDLE = 240;
	localparam int unsigned REG_DENIED_ADDR = 241;
	localparam int unsigned REG_DENIED_TYPE = 242;
	localparam int unsigned REG_STATE = 243;

	// fields of one region config byte
	localparam int unsigned CFG_R = 0;
	localparam int unsigned CFG_W = 1;
	localparam int unsigned CFG_X = 2;
	localparam int unsigned CFG_A_LO = 3;
	localparam int unsigned CFG_A_HI = 4;
	// lock bit, kept but meaningless in user mode
	localparam int unsigned CFG_L = 7;

	// data word returned with every error response
	localparam logic [DATA_W-1:0] ERR_DATA = '1;

	// tilelink a channel opcodes
	typedef enum logic [2:0] {
		PutFullData = 3'd0,
		PutPartialData = 3'd1,
		Get = 3'd4
	} tl_a_op_e;

	// tilelink d channel opcodes
	typedef enum logic [2:0] {
		AccessAck = 3'd0,
		AccessAckData = 3'd1
	} tl_d_op_e;

	// gate fsm states
	typedef enum logic [1:0] {
		idle = 2'd0,
		block_start = 2'd1,
		block_idle = 2'd2,
		block_err = 2'd3
	} guard_state_e;

	// region address matching modes
	typedef enum logic [1:0] {
		off = 2'd0,
		tor = 2'd1,
		na4 = 2'd2,
		napot = 2'd3
	} pmp_mode_e;

endpackage

//--- hdl/pmp_csr_file.sv
// pmp cpu register port
`timescale 1ns/1ps

module pmp_csr_file (
	input  logic                                                          clk,
	input  logic                                                          rst,
	input  logic                                                          cpu_a_valid_i,
	input  pmp_pkg::tl_a_op_e                                             cpu_a_opcode_i,
	input  logic [pmp_pkg::ADDR_W-1:0]                                    cpu_a_address_i,
	input  logic [pmp_pkg::DATA_W-1:0]                                    cpu_a_data_i,
	input  logic [pmp_pkg::MASK_W-1:0]                                    cpu_a_mask_i,
	input  logic [pmp_pkg::SRC_W-1:0]                                     cpu_a_source_i,
	input  logic                                                          cpu_d_ready_i,
	input  pmp_pkg::guard_state_e                                         state_i,
	input  logic [pmp_pkg::ADDR_W-1:0]                                    denied_addr_i,
	input  pmp_pkg::tl_a_op_e                                             denied_type_i,
	output logic                                                          cpu_a_ready_o,
	output logic                                                          cpu_d_valid_o,
	output pmp_pkg::tl_d_op_e                                             cpu_d_opcode_o,
	output logic [pmp_pkg::DATA_W-1:0]                                    cpu_d_data_o,
	output logic [pmp_pkg::SRC_W-1:0]                                     cpu_d_source_o,
	output logic                                                          cpu_d_error_o,
	output logic [pmp_pkg::NUM_REGIONS-1:0][7:0]                          pmp_cfg_o,
	output logic [pmp_pkg::NUM_REGIONS-1:0][pmp_pkg::PMP_ADDR_W-1:0]      pmp_addr_o,
	output logic                                                          go_idle_o
);

	logic [7:0] idx;
	logic accept;
	logic is_put;
	logic is_get;
	logic full_mask;
	logic [pmp_pkg::NUM_REGIONS-1:0] region_sel;
	logic [pmp_pkg::NUM_REGIONS-1:0] addr_we;
	logic cfg_we;
	logic go_idle_we;
	logic rsp_err;
	logic [pmp_pkg::DATA_W-1:0] rd_data;

	// only one beat in flight, so ready just waits for the response to drain
	assign cpu_a_ready_o = !cpu_d_valid_o;
	assign accept = cpu_a_valid_i && cpu_a_ready_o;

	// word index, byte lanes below are not decoded
	assign idx = cpu_a_address_i[9:2];
	assign is_put = (cpu_a_opcode_i == pmp_pkg::PutFullData) ||
		(cpu_a_opcode_i == pmp_pkg::PutPartialData);
	assign is_get = (cpu_a_opcode_i == pmp_pkg::Get);
	// sub-word access is not supported
	assign full_mask = &cpu_a_mask_i;

	always_comb begin
		for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
			region_sel[i] = (idx == pmp_pkg::REG_ADDR_BASE + i);
		end
	end

	// decode, error unless a mapped register accepts the access
	always_comb begin
		cfg_we = 1'b0;
		addr_we = '0;
		go_idle_we = 1'b0;
		rd_data = '0;
		rsp_err = 1'b1;
		if (full_mask && is_put) begin
			if (idx == pmp_pkg::REG_CFG) begin
				cfg_we = 1'b1;
				rsp_err = 1'b0;
			end else if (|region_sel) begin
				addr_we = region_sel;
				rsp_err = 1'b0;
			end else if (idx == pmp_pkg::REG_GO_IDLE) begin
				go_idle_we = 1'b1;
				rsp_err = 1'b0;
			end
			// denied registers and state stay read only
		end else if (full_mask && is_get) begin
			rsp_err = 1'b0;
			if (idx == pmp_pkg::REG_CFG) begin
				rd_data = pmp_cfg_o;
			end else if (|region_sel) begin
				for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
					if (region_sel[i]) begin
						rd_data = {{(pmp_pkg::DATA_W - pmp_pkg::PMP_ADDR_W){1'b0}}, pmp_addr_o[i]};
					end
				end
			end else if (idx == pmp_pkg::REG_DENIED_ADDR) begin
				rd_data = denied_addr_i;
			end else if (idx == pmp_pkg::REG_DENIED_TYPE) begin
				rd_data = {{(pmp_pkg::DATA_W - 3){1'b0}}, denied_type_i};
			end else if (idx == pmp_pkg::REG_STATE) begin
				rd_data = {{(pmp_pkg::DATA_W - 2){1'b0}}, state_i};
			end else begin
				rsp_err = 1'b1;
			end
		end
	end

	// region registers, response valid and the go-idle strobe
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cpu_d_valid_o <= 1'b0;
			go_idle_o <= 1'b0;
			pmp_cfg_o <= '0;
			pmp_addr_o <= '0;
		end else begin
			// single cycle pulse towards the gate fsm
			go_idle_o <= accept && go_idle_we;
			if (accept) begin
				cpu_d_valid_o <= 1'b1;
			end else if (cpu_d_ready_i) begin
				cpu_d_valid_o <= 1'b0;
			end
			if (accept && cfg_we) begin
				pmp_cfg_o <= cpu_a_data_i;
			end
			for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
				if (accept && addr_we[i]) begin
					pmp_addr_o[i] <= cpu_a_data_i[pmp_pkg::PMP_ADDR_W-1:0];
				end
			end
		end
	end

	// response payload, held while d_valid waits for d_ready
	always_ff @(posedge clk) begin
		if (accept) begin
			cpu_d_opcode_o <= is_get ? pmp_pkg::AccessAckData : pmp_pkg::AccessAck;
			cpu_d_data_o <= rsp_err ? pmp_pkg::ERR_DATA : rd_data;
			cpu_d_error_o <= rsp_err;
			cpu_d_source_o <= cpu_a_source_i;
		end
	end

endmodule

//--- hdl/pmp_checker.sv
// pmp region match and permission check
`timescale 1ns/1ps

module pmp_checker (
	input  logic [pmp_pkg::NUM_REGIONS-1:0][7:0]                      pmp_cfg_i,
	input  logic [pmp_pkg::NUM_REGIONS-1:0][pmp_pkg::PMP_ADDR_W-1:0]  pmp_addr_i,
	input  logic [pmp_pkg::ADDR_W-1:0]                                req_addr_i,
	input  pmp_pkg::tl_a_op_e                                         req_opcode_i,
	output logic                                                      deny_o
);

	logic [pmp_pkg::PMP_ADDR_W-1:0] word_addr;
	logic is_get;
	logic is_put;
	logic [pmp_pkg::NUM_REGIONS-1:0] match;
	logic [pmp_pkg::NUM_REGIONS-1:0] allow;

	// regions are compared on word granularity
	assign word_addr = req_addr_i[pmp_pkg::ADDR_W-1:2];
	assign is_get = (req_opcode_i == pmp_pkg::Get);
	assign is_put = (req_opcode_i == pmp_pkg::PutFullData) ||
		(req_opcode_i == pmp_pkg::PutPartialData);

	for (genvar i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin : gen_region
		logic [pmp_pkg::PMP_ADDR_W-1:0] base;
		logic [pmp_pkg::PMP_ADDR_W-1:0] care;
		pmp_pkg::pmp_mode_e mode;
		logic hit;

		// tor lower bound is the previous region, region 0 starts at zero
		if (i == 0) begin : gen_first
			assign base = '0;
		end else begin : gen_next
			assign base = pmp_addr_i[i-1];
		end

		assign mode = pmp_pkg::pmp_mode_e'(pmp_cfg_i[i][pmp_pkg::CFG_A_HI:pmp_pkg::CFG_A_LO]);

		// napot: trailing ones plus the lowest zero are don't care
		// an all ones address therefore covers everything
		assign care = ~(pmp_addr_i[i] ^ (pmp_addr_i[i] + 1'b1));

		always_comb begin
			unique case (mode)
				pmp_pkg::tor: hit = (word_addr >= base) && (word_addr < pmp_addr_i[i]);
				pmp_pkg::na4: hit = (word_addr == pmp_addr_i[i]);
				pmp_pkg::napot: hit = ((word_addr & care) == (pmp_addr_i[i] & care));
				default: hit = 1'b0;
			endcase
		end

		assign match[i] = hit;
		// reads need R, writes need W, anything else never passes
		assign allow[i] = (is_get && pmp_cfg_i[i][pmp_pkg::CFG_R]) ||
			(is_put && pmp_cfg_i[i][pmp_pkg::CFG_W]);
	end

	// lowest matching region wins, walk down so it is assigned last
	// no match in user mode means denied
	always_comb begin
		deny_o = 1'b1;
		for (int i = pmp_pkg::NUM_REGIONS - 1; i >= 0; i--) begin
			if (match[i]) begin
				deny_o = !allow[i];
			end
		end
	end

endmodule

//--- hdl/bus_guard.sv
// host gate fsm and error response
`timescale 1ns/1ps

module bus_guard (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          host_a_valid_i,
	input  pmp_pkg::tl_a_op_e             host_a_opcode_i,
	input  logic [pmp_pkg::ADDR_W-1:0]    host_a_address_i,
	input  logic [pmp_pkg::DATA_W-1:0]    host_a_data_i,
	input  logic [pmp_pkg::MASK_W-1:0]    host_a_mask_i,
	input  logic [pmp_pkg::SRC_W-1:0]     host_a_source_i,
	input  logic                          host_d_ready_i,
	input  logic                          dev_a_ready_i,
	input  logic                          dev_d_valid_i,
	input  pmp_pkg::tl_d_op_e             dev_d_opcode_i,
	input  logic [pmp_pkg::DATA_W-1:0]    dev_d_data_i,
	input  logic [pmp_pkg::SRC_W-1:0]     dev_d_source_i,
	input  logic                          dev_d_error_i,
	input  logic                          deny_i,
	input  logic                          go_idle_i,
	output logic                          host_a_ready_o,
	output logic                          host_d_valid_o,
	output pmp_pkg::tl_d_op_e             host_d_opcode_o,
	output logic [pmp_pkg::DATA_W-1:0]    host_d_data_o,
	output logic [pmp_pkg::SRC_W-1:0]     host_d_source_o,
	output logic                          host_d_error_o,
	output logic                          dev_a_valid_o,
	output pmp_pkg::tl_a_op_e             dev_a_opcode_o,
	output logic [pmp_pkg::ADDR_W-1:0]    dev_a_address_o,
	output logic [pmp_pkg::DATA_W-1:0]    dev_a_data_o,
	output logic [pmp_pkg::MASK_W-1:0]    dev_a_mask_o,
	output logic [pmp_pkg::SRC_W-1:0]     dev_a_source_o,
	output logic                          dev_d_ready_o,
	output logic                          irq_o,
	output pmp_pkg::guard_state_e         state_o,
	output logic [pmp_pkg::ADDR_W-1:0]    denied_addr_o,
	output pmp_pkg::tl_a_op_e             denied_type_o
);

	pmp_pkg::guard_state_e state_q;
	pmp_pkg::guard_state_e next_state;
	logic deny_hit;
	logic pass_d;
	logic [pmp_pkg::SRC_W-1:0] err_source_q;
	pmp_pkg::tl_d_op_e err_opcode;

	assign state_o = state_q;

	// a channel payload goes to the device unchanged, only valid is gated
	assign dev_a_opcode_o = host_a_opcode_i;
	assign dev_a_address_o = host_a_address_i;
	assign dev_a_data_o = host_a_data_i;
	assign dev_a_mask_o = host_a_mask_i;
	assign dev_a_source_o = host_a_source_i;

	// denied beat is swallowed here, the device never sees it
	assign deny_hit = (state_q == pmp_pkg::idle) && host_a_valid_i && dev_a_ready_i && deny_i;

	// a denied Get still expects data back
	assign err_opcode = (denied_type_o == pmp_pkg::Get) ? pmp_pkg::AccessAckData :
		pmp_pkg::AccessAck;

	always_comb begin
		next_state = state_q;
		// blocked unless a state opens a path
		host_a_ready_o = 1'b0;
		dev_a_valid_o = 1'b0;
		dev_d_ready_o = 1'b0;
		pass_d = 1'b0;
		unique case (state_q)
			pmp_pkg::idle: begin
				host_a_ready_o = dev_a_ready_i;
				dev_a_valid_o = host_a_valid_i && !deny_i;
				dev_d_ready_o = host_d_ready_i;
				pass_d = 1'b1;
				if (deny_hit) begin
					next_state = pmp_pkg::block_start;
				end
			end
			pmp_pkg::block_start: begin
				// error response is up, outcome depends on d handshake and release
				if (host_d_ready_i && go_idle_i) begin
					next_state = pmp_pkg::idle;
				end else if (host_d_ready_i) begin
					next_state = pmp_pkg::block_err;
				end else if (go_idle_i) begin
					next_state = pmp_pkg::block_idle;
				end
			end
			pmp_pkg::block_idle: begin
				// already released, just finish the error response
				if (host_d_ready_i) begin
					next_state = pmp_pkg::idle;
				end
			end
			default: begin
				// block_err, late device responses may still drain
				dev_d_ready_o = host_d_ready_i;
				pass_d = 1'b1;
				if (go_idle_i) begin
					next_state = pmp_pkg::idle;
				end
			end
		endcase
	end

	// d channel mux, device pass-through or the held error response
	assign host_d_valid_o = pass_d ? dev_d_valid_i : 1'b1;
	assign host_d_opcode_o = pass_d ? dev_d_opcode_i : err_opcode;
	assign host_d_data_o = pass_d ? dev_d_data_i : pmp_pkg::ERR_DATA;
	assign host_d_source_o = pass_d ? dev_d_source_i : err_source_q;
	assign host_d_error_o = pass_d ? dev_d_error_i : 1'b1;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q <= pmp_pkg::idle;
			irq_o <= 1'b0;
			denied_addr_o <= '0;
			denied_type_o <= pmp_pkg::PutFullData;
		end else begin
			state_q <= next_state;
			// one cycle pulse after the denied beat
			irq_o <= deny_hit;
			if (deny_hit) begin
				denied_addr_o <= host_a_address_i;
				denied_type_o <= host_a_opcode_i;
			end
		end
	end

	// source only matters while the error response is shown
	always_ff @(posedge clk) begin
		if (deny_hit) begin
			err_source_q <= host_a_source_i;
		end
	end

endmodule

//--- hdl/access_control.sv
// pmp access control gate top
`timescale 1ns/1ps

module access_control (
	input  logic                          clk,
	input  logic                          rst,
	output logic                          irq_o,
	// host side
	input  logic                          host_a_valid_i,
	input  pmp_pkg::tl_a_op_e             host_a_opcode_i,
	input  logic [pmp_pkg::ADDR_W-1:0]    host_a_address_i,
	input  logic [pmp_pkg::DATA_W-1:0]    host_a_data_i,
	input  logic [pmp_pkg::MASK_W-1:0]    host_a_mask_i,
	input  logic [pmp_pkg::SRC_W-1:0]     host_a_source_i,
	output logic                          host_a_ready_o,
	output logic                          host_d_valid_o,
	output pmp_pkg::tl_d_op_e             host_d_opcode_o,
	output logic [pmp_pkg::DATA_W-1:0]    host_d_data_o,
	output logic [pmp_pkg::SRC_W-1:0]     host_d_source_o,
	output logic                          host_d_error_o,
	input  logic                          host_d_ready_i,
	// device side
	output logic                          dev_a_valid_o,
	output pmp_pkg::tl_a_op_e             dev_a_opcode_o,
	output logic [pmp_pkg::ADDR_W-1:0]    dev_a_address_o,
	output logic [pmp_pkg::DATA_W-1:0]    dev_a_data_o,
	output logic [pmp_pkg::MASK_W-1:0]    dev_a_mask_o,
	output logic [pmp_pkg::SRC_W-1:0]     dev_a_source_o,
	input  logic                          dev_a_ready_i,
	input  logic                          dev_d_valid_i,
	input  pmp_pkg::tl_d_op_e             dev_d_opcode_i,
	input  logic [pmp_pkg::DATA_W-1:0]    dev_d_data_i,
	input  logic [pmp_pkg::SRC_W-1:0]     dev_d_source_i,
	input  logic                          dev_d_error_i,
	output logic                          dev_d_ready_o,
	// cpu configuration port
	input  logic                          cpu_a_valid_i,
	input  pmp_pkg::tl_a_op_e             cpu_a_opcode_i,
	input  logic [pmp_pkg::ADDR_W-1:0]    cpu_a_address_i,
	input  logic [pmp_pkg::DATA_W-1:0]    cpu_a_data_i,
	input  logic [pmp_pkg::MASK_W-1:0]    cpu_a_mask_i,
	input  logic [pmp_pkg::SRC_W-1:0]     cpu_a_source_i,
	output logic                          cpu_a_ready_o,
	output logic                          cpu_d_valid_o,
	output pmp_pkg::tl_d_op_e             cpu_d_opcode_o,
	output logic [pmp_pkg::DATA_W-1:0]    cpu_d_data_o,
	output logic [pmp_pkg::SRC_W-1:0]     cpu_d_source_o,
	output logic                          cpu_d_error_o,
	input  logic                          cpu_d_ready_i
);

	// region setup from the register file
	logic [pmp_pkg::NUM_REGIONS-1:0][7:0] pmp_cfg;
	logic [pmp_pkg::NUM_REGIONS-1:0][pmp_pkg::PMP_ADDR_W-1:0] pmp_addr;
	// gate control and status
	logic go_idle;
	logic deny;
	pmp_pkg::guard_state_e state;
	logic [pmp_pkg::ADDR_W-1:0] denied_addr;
	pmp_pkg::tl_a_op_e denied_type;

	pmp_csr_file i_pmp_csr_file (
		.clk             (clk),
		.rst             (rst),
		.cpu_a_valid_i   (cpu_a_valid_i),
		.cpu_a_opcode_i  (cpu_a_opcode_i),
		.cpu_a_address_i (cpu_a_address_i),
		.cpu_a_data_i    (cpu_a_data_i),
		.cpu_a_mask_i    (cpu_a_mask_i),
		.cpu_a_source_i  (cpu_a_source_i),
		.cpu_d_ready_i   (cpu_d_ready_i),
		.state_i         (state),
		.denied_addr_i   (denied_addr),
		.denied_type_i   (denied_type),
		.cpu_a_ready_o   (cpu_a_ready_o),
		.cpu_d_valid_o   (cpu_d_valid_o),
		.cpu_d_opcode_o  (cpu_d_opcode_o),
		.cpu_d_data_o    (cpu_d_data_o),
		.cpu_d_source_o  (cpu_d_source_o),
		.cpu_d_error_o   (cpu_d_error_o),
		.pmp_cfg_o       (pmp_cfg),
		.pmp_addr_o      (pmp_addr),
		.go_idle_o       (go_idle)
	);

	// checks the live host request, not a registered copy
	pmp_checker i_pmp_checker (
		.pmp_cfg_i    (pmp_cfg),
		.pmp_addr_i   (pmp_addr),
		.req_addr_i   (host_a_address_i),
		.req_opcode_i (host_a_opcode_i),
		.deny_o       (deny)
	);

	bus_guard i_bus_guard (
		.clk              (clk),
		.rst              (rst),
		.host_a_valid_i   (host_a_valid_i),
		.host_a_opcode_i  (host_a_opcode_i),
		.host_a_address_i (host_a_address_i),
		.host_a_data_i    (host_a_data_i),
		.host_a_mask_i    (host_a_mask_i),
		.host_a_source_i  (host_a_source_i),
		.host_d_ready_i   (host_d_ready_i),
		.dev_a_ready_i    (dev_a_ready_i),
		.dev_d_valid_i    (dev_d_valid_i),
		.dev_d_opcode_i   (dev_d_opcode_i),
		.dev_d_data_i     (dev_d_data_i),
		.dev_d_source_i   (dev_d_source_i),
		.dev_d_error_i    (dev_d_error_i),
		.deny_i           (deny),
		.go_idle_i        (go_idle),
		.host_a_ready_o   (host_a_ready_o),
		.host_d_valid_o   (host_d_valid_o),
		.host_d_opcode_o  (host_d_opcode_o),
		.host_d_data_o    (host_d_data_o),
		.host_d_source_o  (host_d_source_o),
		.host_d_error_o   (host_d_error_o),
		.dev_a_valid_o    (dev_a_valid_o),
		.dev_a_opcode_o   (dev_a_opcode_o),
		.dev_a_address_o  (dev_a_address_o),
		.dev_a_data_o     (dev_a_data_o),
		.dev_a_mask_o     (dev_a_mask_o),
		.dev_a_source_o   (dev_a_source_o),
		.dev_d_ready_o    (dev_d_ready_o),
		.irq_o            (irq_o),
		.state_o          (state),
		.denied_addr_o    (denied_addr),
		.denied_type_o    (denied_type)
	);

endmodule

//--- tests/access_control_tb.sv
// pmp gate testbench
`timescale 1ns/1ps

module access_control_tb;

	logic clk;
	logic rst;
	logic irq;
	// host side
	logic host_a_valid;
	pmp_pkg::tl_a_op_e host_a_opcode;
	logic [31:0] host_a_address;
	logic [31:0] host_a_data;
	logic [3:0] host_a_mask;
	logic [7:0] host_a_source;
	logic host_a_ready;
	logic host_d_valid;
	pmp_pkg::tl_d_op_e host_d_opcode;
	logic [31:0] host_d_data;
	logic [7:0] host_d_source;
	logic host_d_error;
	logic host_d_ready;
	// device side
	logic dev_a_valid;
	pmp_pkg::tl_a_op_e dev_a_opcode;
	logic [31:0] dev_a_address;
	logic [31:0] dev_a_data;
	logic [3:0] dev_a_mask;
	logic [7:0] dev_a_source;
	logic dev_a_ready;
	logic dev_d_valid;
	pmp_pkg::tl_d_op_e dev_d_opcode;
	logic [31:0] dev_d_data;
	logic [7:0] dev_d_source;
	logic dev_d_error;
	logic dev_d_ready;
	// cpu port
	logic cpu_a_valid;
	pmp_pkg::tl_a_op_e cpu_a_opcode;
	logic [31:0] cpu_a_address;
	logic [31:0] cpu_a_data;
	logic [3:0] cpu_a_mask;
	logic [7:0] cpu_a_source;
	logic cpu_a_ready;
	logic cpu_d_valid;
	pmp_pkg::tl_d_op_e cpu_d_opcode;
	logic [31:0] cpu_d_data;
	logic [7:0] cpu_d_source;
	logic cpu_d_error;
	logic cpu_d_ready;

	// last captured d beat, from either bus
	string rsp_bus;
	pmp_pkg::tl_d_op_e d_op;
	logic d_err;
	logic [31:0] d_data;
	logic [7:0] d_src;
	logic [7:0] cpu_src;
	logic [31:0] lfsr = 32'hf59d_b488;
	int dev_beats = 0;
	int cycle_count = 0;

	access_control i_access_control (
		.clk(clk), .rst(rst), .irq_o(irq),
		.host_a_valid_i(host_a_valid), .host_a_opcode_i(host_a_opcode),
		.host_a_address_i(host_a_address), .host_a_data_i(host_a_data),
		.host_a_mask_i(host_a_mask), .host_a_source_i(host_a_source),
		.host_a_ready_o(host_a_ready), .host_d_valid_o(host_d_valid),
		.host_d_opcode_o(host_d_opcode), .host_d_data_o(host_d_data),
		.host_d_source_o(host_d_source), .host_d_error_o(host_d_error),
		.host_d_ready_i(host_d_ready),
		.dev_a_valid_o(dev_a_valid), .dev_a_opcode_o(dev_a_opcode),
		.dev_a_address_o(dev_a_address), .dev_a_data_o(dev_a_data),
		.dev_a_mask_o(dev_a_mask), .dev_a_source_o(dev_a_source),
		.dev_a_ready_i(dev_a_ready), .dev_d_valid_i(dev_d_valid),
		.dev_d_opcode_i(dev_d_opcode), .dev_d_data_i(dev_d_data),
		.dev_d_source_i(dev_d_source), .dev_d_error_i(dev_d_error),
		.dev_d_ready_o(dev_d_ready),
		.cpu_a_valid_i(cpu_a_valid), .cpu_a_opcode_i(cpu_a_opcode),
		.cpu_a_address_i(cpu_a_address), .cpu_a_data_i(cpu_a_data),
		.cpu_a_mask_i(cpu_a_mask), .cpu_a_source_i(cpu_a_source),
		.cpu_a_ready_o(cpu_a_ready), .cpu_d_valid_o(cpu_d_valid),
		.cpu_d_opcode_o(cpu_d_opcode), .cpu_d_data_o(cpu_d_data),
		.cpu_d_source_o(cpu_d_source), .cpu_d_error_o(cpu_d_error),
		.cpu_d_ready_i(cpu_d_ready)
	);

	// 100 ns clock
	initial clk = 1'b0;
	always #50 clk = ~clk;

	// device model, always ready, answers one cycle after the a beat
	// Get returns the inverted address
	always @(posedge clk) begin
		if (dev_a_valid && dev_a_ready) begin
			dev_beats <= dev_beats + 1;
			dev_d_valid <= 1'b1;
			dev_d_source <= dev_a_source;
			dev_d_error <= 1'b0;
			if (dev_a_opcode == pmp_pkg::Get) begin
				dev_d_opcode <= pmp_pkg::AccessAckData;
				dev_d_data <= ~dev_a_address;
			end else begin
				dev_d_opcode <= pmp_pkg::AccessAck;
				dev_d_data <= '0;
			end
		end else if (dev_d_ready) begin
			dev_d_valid <= 1'b0;
		end
	end

	// tests take roughly 600 cycles, the limit leaves a wide margin
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= 4000) begin
			$display("timeout: run did not finish within %0d cycles", cycle_count);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'ha300_0000 : 32'h0);
			bits = {bits[30:0], lfsr[0]};
		end
		return bits;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_true(input string what, input bit cond);
		assert (cond) else begin
			$display("error at %0t ns: %s", $time, what);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_resp(input pmp_pkg::tl_d_op_e exp_op, input logic exp_err,
			input logic [7:0] exp_src, input bit with_data, input logic [31:0] exp_data);
		check_value({rsp_bus, "_d_opcode"}, d_op, exp_op);
		check_value({rsp_bus, "_d_error"}, d_err, exp_err);
		check_value({rsp_bus, "_d_source"}, d_src, exp_src);
		if (with_data) begin
			check_value({rsp_bus, "_d_data"}, d_data, exp_data);
		end
	endtask

	task automatic capture_host_d();
		rsp_bus = "host";
		d_op = host_d_opcode;
		d_err = host_d_error;
		d_data = host_d_data;
		d_src = host_d_source;
	endtask

	// one cpu beat, response left in the capture variables
	task automatic cpu_access(input pmp_pkg::tl_a_op_e op, input int idx,
			input logic [31:0] data, input logic [3:0] mask);
		cpu_src = take_bits(8);
		@(posedge clk);
		cpu_a_valid <= 1'b1;
		cpu_a_opcode <= op;
		cpu_a_address <= idx * 4;
		cpu_a_data <= data;
		cpu_a_mask <= mask;
		cpu_a_source <= cpu_src;
		// sample at the falling edge, handshake happens on the next rise
		do @(negedge clk); while (!cpu_a_ready);
		@(posedge clk);
		cpu_a_valid <= 1'b0;
		do @(negedge clk); while (!cpu_d_valid);
		rsp_bus = "cpu";
		d_op = cpu_d_opcode;
		d_err = cpu_d_error;
		d_data = cpu_d_data;
		d_src = cpu_d_source;
	endtask

	task automatic cpu_write(input int idx, input logic [31:0] data);
		cpu_access(pmp_pkg::PutFullData, idx, data, 4'hf);
		check_resp(pmp_pkg::AccessAck, 1'b0, cpu_src, 1'b0, '0);
	endtask

	task automatic cpu_read(input int idx, input logic [31:0] exp);
		cpu_access(pmp_pkg::Get, idx, '0, 4'hf);
		check_resp(pmp_pkg::AccessAckData, 1'b0, cpu_src, 1'b1, exp);
	endtask

	// host beat through the gate, checks device side and the irq pulse
	task automatic host_access(input pmp_pkg::tl_a_op_e op, input logic [31:0] addr,
			input logic [31:0] data, input logic [7:0] src, input bit exp_pass);
		@(posedge clk);
		host_a_valid <= 1'b1;
		host_a_opcode <= op;
		host_a_address <= addr;
		host_a_data <= data;
		host_a_mask <= 4'hf;
		host_a_source <= src;
		host_d_ready <= 1'b1;
		do @(negedge clk); while (!host_a_ready);
		check_value("dev_a_valid", dev_a_valid, exp_pass);
		if (exp_pass) begin
			check_value("dev_a_opcode", dev_a_opcode, op);
			check_value("dev_a_address", dev_a_address, addr);
			check_value("dev_a_data", dev_a_data, data);
			check_value("dev_a_mask", dev_a_mask, 4'hf);
			check_value("dev_a_source", dev_a_source, src);
		end
		@(posedge clk);
		host_a_valid <= 1'b0;
		@(negedge clk);
		// irq only in the cycle right after a denied beat
		check_value("irq_o", irq, !exp_pass);
		while (!host_d_valid) @(negedge clk);
		capture_host_d();
		// device d channel is stalled while the error response is shown
		check_value("dev_d_ready", dev_d_ready, exp_pass);
		@(negedge clk);
		check_value("irq_o", irq, 1'b0);
	endtask

	task automatic release_gate();
		cpu_write(pmp_pkg::REG_GO_IDLE, '0);
		cpu_read(pmp_pkg::REG_STATE, pmp_pkg::idle);
	endtask

	// random source and data, full response check, denials get released
	task automatic probe(input pmp_pkg::tl_a_op_e op, input logic [31:0] addr, input bit exp_pass);
		logic [7:0] src;
		logic [31:0] data;
		int beats;
		pmp_pkg::tl_d_op_e exp_op;
		src = take_bits(8);
		data = take_bits(32);
		beats = dev_beats;
		exp_op = (op == pmp_pkg::Get) ? pmp_pkg::AccessAckData : pmp_pkg::AccessAck;
		host_access(op, addr, data, src, exp_pass);
		if (exp_pass) begin
			check_resp(exp_op, 1'b0, src, op == pmp_pkg::Get, ~addr);
			check_value("device beat count", dev_beats, beats + 1);
		end else begin
			check_resp(exp_op, 1'b1, src, 1'b1, pmp_pkg::ERR_DATA);
			check_value("device beat count", dev_beats, beats);
			cpu_read(pmp_pkg::REG_DENIED_ADDR, addr);
			cpu_read(pmp_pkg::REG_DENIED_TYPE, op);
			cpu_read(pmp_pkg::REG_STATE, pmp_pkg::block_err);
			release_gate();
		end
	endtask

	// host keeps asking while blocked, nothing may get through
	task automatic blocked_beats();
		@(posedge clk);
		host_a_valid <= 1'b1;
		host_a_opcode <= pmp_pkg::Get;
		host_a_address <= 32'h1800;
		repeat (4) begin
			@(negedge clk);
			check_true("host beat accepted while blocked", !host_a_ready);
			check_true("device request raised while blocked", !dev_a_valid);
			// late device responses still drain in block_err
			check_value("dev_d_ready", dev_d_ready, 1'b1);
		end
		@(posedge clk);
		host_a_valid <= 1'b0;
	endtask

	task automatic test_registers();
		for (int i = 0; i <= 4; i++) begin
			cpu_read(i, '0);
		end
		cpu_read(pmp_pkg::REG_DENIED_ADDR, '0);
		cpu_read(pmp_pkg::REG_DENIED_TYPE, '0);
		cpu_read(pmp_pkg::REG_STATE, pmp_pkg::idle);
		// no region yet, so the write is refused
		probe(pmp_pkg::PutFullData, 32'h1000, 1'b0);
		// r0 na4 R, r1 tor RW, r2 napot R, r3 napot RW
		cpu_write(pmp_pkg::REG_CFG, 32'h1b19_0b11);
		cpu_write(pmp_pkg::REG_ADDR_BASE + 0, 32'h0000_0400);
		cpu_write(pmp_pkg::REG_ADDR_BASE + 1, 32'h0000_0800);
		cpu_write(pmp_pkg::REG_ADDR_BASE + 2, 32'h0000_21ff);
		cpu_write(pmp_pkg::REG_ADDR_BASE + 3, 32'h0000_2fff);
		cpu_read(pmp_pkg::REG_CFG, 32'h1b19_0b11);
		cpu_read(pmp_pkg::REG_ADDR_BASE + 0, 32'h0000_0400);
		cpu_read(pmp_pkg::REG_ADDR_BASE + 1, 32'h0000_0800);
		cpu_read(pmp_pkg::REG_ADDR_BASE + 2, 32'h0000_21ff);
		cpu_read(pmp_pkg::REG_ADDR_BASE + 3, 32'h0000_2fff);
		// error responses
		cpu_access(pmp_pkg::PutFullData, pmp_pkg::REG_CFG, 32'h0, 4'b0011);
		check_resp(pmp_pkg::AccessAck, 1'b1, cpu_src, 1'b1, pmp_pkg::ERR_DATA);
		cpu_read(pmp_pkg::REG_CFG, 32'h1b19_0b11);
		cpu_access(pmp_pkg::Get, 100, '0, 4'hf);
		check_resp(pmp_pkg::AccessAckData, 1'b1, cpu_src, 1'b1, pmp_pkg::ERR_DATA);
		cpu_access(pmp_pkg::PutFullData, pmp_pkg::REG_STATE, 32'h3, 4'hf);
		check_resp(pmp_pkg::AccessAck, 1'b1, cpu_src, 1'b1, pmp_pkg::ERR_DATA);
	endtask

	task automatic test_permitted();
		pmp_pkg::tl_a_op_e op;
		logic [31:0] addr;
		// random words inside the read-write tor region
		repeat (24) begin
			op = take_bits(1) ? pmp_pkg::Get : pmp_pkg::PutFullData;
			addr = 32'h1400 + (take_bits(9) << 2);
			probe(op, addr, 1'b1);
		end
	endtask

	task automatic test_denied();
		logic [7:0] src;
		int beats;
		src = take_bits(8);
		beats = dev_beats;
		// na4 region 0 is read only
		host_access(pmp_pkg::PutFullData, 32'h1000, take_bits(32), src, 1'b0);
		check_resp(pmp_pkg::AccessAck, 1'b1, src, 1'b1, pmp_pkg::ERR_DATA);
		check_value("device beat count", dev_beats, beats);
		cpu_read(pmp_pkg::REG_DENIED_ADDR, 32'h1000);
		cpu_read(pmp_pkg::REG_DENIED_TYPE, pmp_pkg::PutFullData);
		cpu_read(pmp_pkg::REG_STATE, pmp_pkg::block_err);
		blocked_beats();
		cpu_read(pmp_pkg::REG_STATE, pmp_pkg::block_err);
	endtask

	task automatic test_release();
		logic [7:0] src;
		release_gate();
		probe(pmp_pkg::Get, 32'h1800, 1'b1);
		// denial with the host stalling its d channel
		src = take_bits(8);
		@(posedge clk);
		host_a_valid <= 1'b1;
		host_a_opcode <= pmp_pkg::Get;
		host_a_address <= 32'h2000;
		host_a_source <= src;
		host_d_ready <= 1'b0;
		do @(negedge clk); while (!host_a_ready);
		@(posedge clk);
		host_a_valid <= 1'b0;
		@(negedge clk);
		check_true("error response missing", host_d_valid);
		capture_host_d();
		check_resp(pmp_pkg::AccessAckData, 1'b1, src, 1'b1, pmp_pkg::ERR_DATA);
		cpu_write(pmp_pkg::REG_GO_IDLE, '0);
		cpu_read(pmp_pkg::REG_STATE, pmp_pkg::block_idle);
		// response still held after many stalled cycles
		@(negedge clk);
		check_true("error response dropped under back-pressure", host_d_valid);
		capture_host_d();
		check_resp(pmp_pkg::AccessAckData, 1'b1, src, 1'b1, pmp_pkg::ERR_DATA);
		@(posedge clk);
		host_d_ready <= 1'b1;
		@(negedge clk);
		check_true("error response dropped before d_ready", host_d_valid);
		cpu_read(pmp_pkg::REG_STATE, pmp_pkg::idle);
	endtask

	task automatic test_regions();
		// na4 word and its overlap with the tor region
		probe(pmp_pkg::Get, 32'h1000, 1'b1);
		probe(pmp_pkg::PutFullData, 32'h1000, 1'b0);
		probe(pmp_pkg::Get, 32'h0ffc, 1'b0);
		// tor covers 0x1000 up to but not including 0x2000
		probe(pmp_pkg::PutFullData, 32'h1004, 1'b1);
		probe(pmp_pkg::PutFullData, 32'h1ffc, 1'b1);
		probe(pmp_pkg::PutFullData, 32'h2000, 1'b0);
		// 4k read only napot inside a 32k read-write napot
		probe(pmp_pkg::Get, 32'h8000, 1'b1);
		probe(pmp_pkg::PutFullData, 32'h8ffc, 1'b0);
		probe(pmp_pkg::PutFullData, 32'h9000, 1'b1);
		probe(pmp_pkg::Get, 32'hfffc, 1'b1);
		probe(pmp_pkg::Get, 32'h0001_0000, 1'b0);
	endtask

	initial begin
		rst = 1'b0;
		host_a_valid = 1'b0;
		host_a_opcode = pmp_pkg::Get;
		host_a_address = '0;
		host_a_data = '0;
		host_a_mask = '0;
		host_a_source = '0;
		host_d_ready = 1'b1;
		dev_a_ready = 1'b1;
		dev_d_valid = 1'b0;
		dev_d_opcode = pmp_pkg::AccessAck;
		dev_d_data = '0;
		dev_d_source = '0;
		dev_d_error = 1'b0;
		cpu_a_valid = 1'b0;
		cpu_a_opcode = pmp_pkg::Get;
		cpu_a_address = '0;
		cpu_a_data = '0;
		cpu_a_mask = '0;
		cpu_a_source = '0;
		cpu_d_ready = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		check_value("irq_o", irq, 1'b0);
		check_value("host_d_valid", host_d_valid, 1'b0);
		check_value("cpu_d_valid", cpu_d_valid, 1'b0);
		test_registers();
		test_permitted();
		test_denied();
		test_release();
		test_regions();
		$display("All tests passed");
		$finish;
	end

endmodule

//--- project.f
hdl/pmp_pkg.sv
hdl/pmp_csr_file.sv
hdl/pmp_checker.sv
hdl/bus_guard.sv
hdl/access_control.sv
tests/access_control_tb.sv

//--- Bender.yml
package:
  name: access_control

sources:
  - hdl/pmp_pkg.sv
  - hdl/pmp_csr_file.sv
  - hdl/pmp_checker.sv
  - hdl/bus_guard.sv
  - hdl/access_control.sv
  - target: test
    files:
      - tests/access_control_tb.sv
